/* bench/heapGolden.txt */
// op array index data, then expected data and expected error, all hex; op f ends the list
0 0 0 0000 0000 0
1 0 0 0000 0000 0
1 0 0 0000 0001 0
1 0 0 0000 0002 0
1 0 0 0000 0003 0
1 0 0 0000 0004 0
1 0 0 0000 0005 0
1 0 0 0000 0006 0
1 0 0 0000 0007 0
3 2 0 00aa 00aa 0
3 5 7 0055 0055 0
1 2 0 0000 0000 6
2 2 0 0000 0000 0
2 5 0 0000 0000 0
1 2 0 0000 0005 0
1 2 0 0000 0002 0
3 2 3 1234 1234 0
5 2 0 0000 0004 0
4 2 3 0000 1234 0
7 5 0 0000 0000 5
6 5 0 0101 0000 0
6 5 0 0202 0000 0
6 5 0 0303 0000 0
7 5 0 0000 0303 0
7 5 0 0000 0202 0
4 5 2 0000 0000 3
8 5 1 0001 0000 3
3 2 7 0777 0777 0
6 2 0 4444 0000 4
8 2 3 0011 1245 0
9 2 3 0001 1245 0
a 2 3 2000 f246 0
b 2 3 0ff0 0240 0
c 2 3 8001 8241 0
d 2 3 ffff 7dbe 0
8 5 0 ff00 0001 0
0 0 0 0000 0000 0
1 0 0 0000 0000 0
4 5 7 0000 0000 1
3 0 0 abcd abcd 0
2 0 0 0000 0000 0
4 0 0 0000 0000 2
f 0 0 0000 0000 0

/* arrayHeap.f */
hw/heapPkg.sv
hw/commandQueue.sv
hw/arrayTable.sv
hw/elementStore.sv
hw/arrayHeap.sv
bench/arrayHeapBench.sv

/* Bender.yml */
package:
  name: array_heap

sources:
  - hw/heapPkg.sv
  - hw/commandQueue.sv
  - hw/arrayTable.sv
  - hw/elementStore.sv
  - hw/arrayHeap.sv
  - target: test
    files:
      - bench/arrayHeapBench.sv

/* bench/arrayHeapBench.sv */
//--------------------------------------------------------------------------
// Array heap testbench
// Replays golden commands under credit control and checks every response
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module arrayHeapBench;
  import heapPkg::*;

  localparam int MaxLines = 64;                     // Room in the golden table
  localparam int Fields   = 6;                      // Words per golden line

  logic        clock;
  logic        reset;
  logic        cmdValid;
  heapCommand  cmd;
  logic        cmdCredit;
  logic        respValid;
  heapResponse resp;

  logic [15:0] golden [MaxLines*Fields];            // Op, array, index, data, expected
  int          lineCount;                           // Commands before the end marker
  int          respCount;                           // Responses checked so far
  int          credits;                             // Credits the requester holds
  logic [15:0] lfsr;                                // Gap generator state

  arrayHeap DUT (
    .clock     (clock),
    .reset     (reset),
    .cmdValid  (cmdValid),
    .cmd       (cmd),
    .cmdCredit (cmdCredit),
    .respValid (respValid),
    .resp      (resp)
  );

  always #2 clock = ~clock;                         // 4 ns period

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compareValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
    if (got !== expected)
      stopWithFailure($sformatf("Fail at %0t: %s is %h, expected %h",
                                $time, name, got, expected));
  endtask

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // One clock, then credit bookkeeping for that edge
  task automatic stepCycle();
    @(posedge clock);
    credits = credits + int'(cmdCredit) - int'(cmdValid);   // Returned minus spent
    if (credits > QueueDepth)
      stopWithFailure("More credits came back than commands were sent");
    #1;                                             // Drive point after the edge
  endtask

  //------------------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------------------
  initial begin
    logic [1:0] gap;
    clock     = 1'b0;
    reset     = 1'b0;
    cmdValid  = 1'b0;
    cmd       = '0;
    credits   = QueueDepth;
    respCount = 0;
    lfsr      = 16'd63347;
    $readmemh("bench/heapGolden.txt", golden);
    lineCount = 0;
    while (golden[lineCount*Fields] !== 16'h000f) begin   // Op f ends the list
      if (lineCount == MaxLines - 1 || $isunknown(golden[lineCount*Fields]))
        stopWithFailure("Golden file is missing or has no end marker");
      lineCount++;
    end
    if (lineCount == 0)
      stopWithFailure("Golden file holds no commands");
    repeat (3) @(posedge clock);                    // Reset for 3 cycles
    #1 reset = 1'b1;
    for (int i = 0; i < lineCount; i++) begin
      lfsr   = lfsrStep(lfsr);                      // One step per gap bit
      gap[0] = lfsr[0];
      lfsr   = lfsrStep(lfsr);
      gap[1] = lfsr[0];
      cmdValid = 1'b0;
      repeat (gap) stepCycle();                     // Idle 0 to 3 cycles
      while (credits == 0) stepCycle();             // Hold until a credit returns
      cmd.op    = heapOp'(golden[i*Fields][3:0]);
      cmd.array = arrayId'(golden[i*Fields+1]);
      cmd.index = elemIndex'(golden[i*Fields+2]);
      cmd.data  = golden[i*Fields+3];
      cmdValid  = 1'b1;
      stepCycle();
    end
    cmdValid = 1'b0;
    while (respCount < lineCount) stepCycle();      // Drain the pipeline
    if (credits == QueueDepth) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stopWithFailure("Credits held at the end do not match the queue depth");
    end
  end

  //------------------------------------------------------------------------
  // Response check in command order
  //------------------------------------------------------------------------
  always @(posedge clock) begin
    if (reset && respValid) begin
      if (respCount >= lineCount)
        stopWithFailure("A response arrived with no command left to answer");
      compareValue("resp.data", resp.data, golden[respCount*Fields+4]);
      compareValue("resp.error", 16'(resp.error), golden[respCount*Fields+5]);
      respCount = respCount + 1;
    end
  end

  // Watchdog over 10 cycles per command plus a fixed margin
  initial begin
    wait (reset === 1'b1);                          // Golden table counted by now
    repeat (lineCount * 10 + 100) @(posedge clock);
    stopWithFailure("Timeout, not all responses arrived in time");
  end

endmodule

/* hw/arrayHeap.sv */
//--------------------------------------------------------------------------
// Array heap top level
// Command queue feeding the bookkeeping stage and the element store
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module arrayHeap (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 cmdValid,
  input  heapPkg::heapCommand  cmd,
  output logic                 cmdCredit,
  output logic                 respValid,
  output heapPkg::heapResponse resp
);
  import heapPkg::*;

  logic        issueValid;                          // Queue to table
  heapCommand  issueCmd;
  logic        storeValid;                          // Table to store
  storeRequest storeReq;

  commandQueue cmdQueue (
    .clock      (clock),
    .reset      (reset),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .cmdCredit  (cmdCredit),
    .issueValid (issueValid),
    .issueCmd   (issueCmd)
  );

  arrayTable tableStage (
    .clock      (clock),
    .reset      (reset),
    .issueValid (issueValid),
    .issueCmd   (issueCmd),
    .storeValid (storeValid),
    .storeReq   (storeReq)
  );

  elementStore storeStage (
    .clock      (clock),
    .reset      (reset),
    .storeValid (storeValid),
    .storeReq   (storeReq),
    .respValid  (respValid),
    .resp       (resp)
  );

endmodule

/* hw/elementStore.sv */
//--------------------------------------------------------------------------
// Element store
// Element memory and arithmetic stage that forms each command's response
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module elementStore (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 storeValid,
  input  heapPkg::storeRequest storeReq,
  output logic                 respValid,
  output heapPkg::heapResponse resp
);
  import heapPkg::*;

  elemData                          mem [ArrayCount*ElementCount];  // Fixed block per array
  logic [ArrayBits+IndexBits-1:0]   addr;               // Array and index joined
  elemData                          oldValue;           // Element before the op
  elemData                          newValue;           // Element after the op
  logic                             memWrite;
  elemData                          respData;
  logic                             accepted;           // Valid and passed checks

  assign addr     = {storeReq.array, storeReq.index};
  assign oldValue = mem[addr];                          // Sees last cycle's write
  assign accepted = storeValid && storeReq.error == errNone;
  assign memWrite = accepted && storeReq.op inside {opWrite, opPush, opAdd, opAddAfter,
                                                    opSubtract, opAnd, opOr, opXor};

  always_comb begin
    case (storeReq.op)
      opWrite, opPush:   newValue = storeReq.data;
      opAdd, opAddAfter: newValue = oldValue + storeReq.data;    // Wraps at 16 bits
      opSubtract:        newValue = oldValue - storeReq.data;
      opAnd:             newValue = oldValue & storeReq.data;
      opOr:              newValue = oldValue | storeReq.data;
      opXor:             newValue = oldValue ^ storeReq.data;
      default:           newValue = oldValue;
    endcase
  end

  always_comb begin
    respData = '0;                                      // Clear, free, push, errors
    if (storeReq.error == errNone) begin
      case (storeReq.op)
        opAlloc, opSize: respData = elemData'(storeReq.tableValue);
        opWrite:         respData = storeReq.data;
        opRead, opPop:   respData = oldValue;
        opAddAfter:      respData = oldValue;           // Value before the add
        opAdd, opSubtract, opAnd, opOr, opXor:
                         respData = newValue;
        default:         respData = '0;
      endcase
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) respValid <= 1'b0;
    else respValid <= storeValid;
  end

  always_ff @(posedge clock) begin
    if (memWrite) mem[addr] <= newValue;
    resp.data  <= respData;
    resp.error <= storeReq.error;
  end

  // A rejected command leaves its element untouched
  rejectedNoWrite: assert property (
    @(posedge clock) disable iff (!reset)
      (storeValid && storeReq.error != errNone) |=> mem[$past(addr)] === $past(oldValue)
  );

endmodule

/* hw/arrayTable.sv */
//--------------------------------------------------------------------------
// Array table
// Bookkeeping stage for allocation flags, sizes and the free stack
// Checks each command, resolves the element index and steers the store
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module arrayTable (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issueValid,
  input  heapPkg::heapCommand  issueCmd,
  output logic                 storeValid,
  output heapPkg::storeRequest storeReq
);
  import heapPkg::*;

  logic [ArrayCount-1:0] allocated;                 // Per-array allocated flag
  arraySize              sizes     [ArrayCount];    // Current size of each array
  arrayId                freeStack [ArrayCount];    // Freed arrays, last freed on top
  logic [ArrayBits:0]    freeTop;                   // Entries on the free stack
  logic [ArrayBits:0]    handedOut;                 // Array numbers given out so far

  logic [ArrayBits:0]    popTop;                    // Slot below the stack top
  arraySize              curSize;                   // Size of the addressed array
  logic                  fromStack;                 // Alloc reuses a freed array
  arrayId                allocId;                   // Array an alloc would get
  logic                  needsElement;              // Op reads an existing element
  heapError              checkError;
  storeRequest           nextReq;
  logic                  doUpdate;                  // Command passes its checks

  //------------------------------------------------------------------------
  // Checks and index resolution
  //------------------------------------------------------------------------
  always_comb begin
    popTop       = freeTop - 1'b1;
    curSize      = sizes[issueCmd.array];
    fromStack    = freeTop != '0;
    allocId      = fromStack ? freeStack[popTop[ArrayBits-1:0]] : arrayId'(handedOut);
    needsElement = issueCmd.op inside {opRead, opAdd, opAddAfter, opSubtract,
                                       opAnd, opOr, opXor};

    checkError = errNone;
    case (issueCmd.op)
      opClear: checkError = errNone;                // Always allowed
      opAlloc: begin
        if (!fromStack && handedOut == ArrayCount) checkError = errNoMemory;
      end
      default: begin
        if ({1'b0, issueCmd.array} >= handedOut) checkError = errUnknown;
        else if (!allocated[issueCmd.array]) checkError = errFreed;
        else if (needsElement && {1'b0, issueCmd.index} >= curSize) checkError = errBounds;
        else if (issueCmd.op == opPush && curSize == ElementCount) checkError = errFull;
        else if (issueCmd.op == opPop && curSize == '0) checkError = errEmpty;
      end
    endcase

    nextReq.op         = issueCmd.op;
    nextReq.array      = issueCmd.array;
    nextReq.index      = issueCmd.index;
    nextReq.data       = issueCmd.data;
    nextReq.tableValue = curSize;                   // Size for opSize
    nextReq.error      = checkError;
    case (issueCmd.op)
      opAlloc: nextReq.tableValue = {1'b0, allocId};      // Number handed back
      opPush:  nextReq.index = elemIndex'(curSize);       // Append at old size
      opPop:   nextReq.index = elemIndex'(curSize - 1'b1); // Top at new size
      default: ;
    endcase
  end

  assign doUpdate = issueValid && checkError == errNone;

  //------------------------------------------------------------------------
  // Control state
  //------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated  <= '0;
      freeTop    <= '0;
      handedOut  <= '0;
      storeValid <= 1'b0;
    end else begin
      storeValid <= issueValid;                     // One cycle per stage
      if (doUpdate) begin
        case (issueCmd.op)
          opClear: begin                            // Empty the heap
            allocated <= '0;
            freeTop   <= '0;
            handedOut <= '0;
          end
          opAlloc: begin
            allocated[allocId] <= 1'b1;
            if (fromStack) freeTop <= popTop;       // Reuse last freed
            else handedOut <= handedOut + 1'b1;     // Fresh number
          end
          opFree: begin
            allocated[issueCmd.array] <= 1'b0;
            freeTop <= freeTop + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Sizes, free stack and the stage register
  always_ff @(posedge clock) begin
    storeReq <= nextReq;
    if (doUpdate) begin
      case (issueCmd.op)
        opAlloc: sizes[allocId] <= '0;              // New array starts empty
        opFree:  freeStack[freeTop[ArrayBits-1:0]] <= issueCmd.array;
        opWrite: begin
          if ({1'b0, issueCmd.index} >= curSize)    // Write past end extends
            sizes[issueCmd.array] <= arraySize'(issueCmd.index) + 1'b1;
        end
        opPush:  sizes[issueCmd.array] <= curSize + 1'b1;
        opPop:   sizes[issueCmd.array] <= curSize - 1'b1;
        default: ;
      endcase
    end
  end

  // Free stack never holds more arrays than were handed out
  freeStackBound: assert property (
    @(posedge clock) disable iff (!reset)
      freeTop <= handedOut && freeTop <= ArrayCount
  );

endmodule

/* hw/commandQueue.sv */
//--------------------------------------------------------------------------
// Command queue
// Circular FIFO for credited commands, one credit back per issued command
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module commandQueue (
  input  logic                clock,
  input  logic                reset,
  input  logic                cmdValid,
  input  heapPkg::heapCommand cmd,
  output logic                cmdCredit,
  output logic                issueValid,
  output heapPkg::heapCommand issueCmd
);
  import heapPkg::*;

  heapCommand                    entries [QueueDepth];  // FIFO storage
  logic [$clog2(QueueDepth)-1:0] writePtr;              // Next slot to fill
  logic [$clog2(QueueDepth)-1:0] readPtr;               // Oldest entry
  logic [$clog2(QueueDepth):0]   count;                 // Occupancy 0 to QueueDepth

  assign issueValid = count != '0;                      // Issue whenever not empty
  assign issueCmd   = entries[readPtr];
  assign cmdCredit  = issueValid;                       // Each pop frees one slot

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
    end else begin
      if (cmdValid) writePtr <= writePtr + 1'b1;        // Wraps at the power-of-two depth
      if (issueValid) readPtr <= readPtr + 1'b1;
      case ({cmdValid, issueValid})
        2'b10:   count <= count + 1'b1;                 // Write only
        2'b01:   count <= count - 1'b1;                 // Pop only
        default: count <= count;                        // Both or neither
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (cmdValid) entries[writePtr] <= cmd;             // Payload storage
  end

  //------------------------------------------------------------------------
  // Credit protocol
  //------------------------------------------------------------------------
  // A write into a full queue means the requester spent a credit it never had
  creditRespected: assert property (
    @(posedge clock) disable iff (!reset)
      !(cmdValid && count == QueueDepth)
  );

endmodule

/* hw/heapPkg.sv */
//--------------------------------------------------------------------------
// Array heap shared definitions
// Widths, opcode and error kinds, and the structs passed between stages
//--------------------------------------------------------------------------
package heapPkg;

  localparam int ArrayBits    = 3;                  // Bits in an array number
  localparam int IndexBits    = 3;                  // Bits in an element index
  localparam int DataBits     = 16;                 // Element width
  localparam int ArrayCount   = 2 ** ArrayBits;     // Arrays in the heap
  localparam int ElementCount = 2 ** IndexBits;     // Elements per array
  localparam int QueueDepth   = 4;                  // FIFO entries and initial credits

  typedef logic [ArrayBits-1:0] arrayId;            // Array number
  typedef logic [IndexBits-1:0] elemIndex;          // Element index
  typedef logic [IndexBits:0]   arraySize;          // Size 0 to ElementCount
  typedef logic [DataBits-1:0]  elemData;           // Element value

  typedef enum logic [3:0] {
    opClear, opAlloc, opFree,                       // Heap management
    opWrite, opRead, opSize,                        // Plain element access
    opPush, opPop,                                  // Stack use of an array
    opAdd, opAddAfter, opSubtract,                  // Arithmetic read-modify-write
    opAnd, opOr, opXor                              // Bitwise read-modify-write
  } heapOp;

  typedef enum logic [2:0] {
    errNone,                                        // Command completed
    errUnknown,                                     // Array number never handed out
    errFreed,                                       // Array not allocated now
    errBounds,                                      // Index not below size
    errFull,                                        // Push on a full array
    errEmpty,                                       // Pop on an empty array
    errNoMemory                                     // No array left to allocate
  } heapError;

  typedef struct packed {
    heapOp    op;                                   // Operation
    arrayId   array;                                // Target array
    elemIndex index;                                // Element within the array
    elemData  data;                                 // Operand
  } heapCommand;

  typedef struct packed {
    elemData  data;                                 // Result value
    heapError error;                                // Outcome
  } heapResponse;

  typedef struct packed {
    heapOp    op;                                   // Operation
    arrayId   array;                                // Target array
    elemIndex index;                                // Resolved element index
    elemData  data;                                 // Operand from the command
    arraySize tableValue;                           // Size or allocated array number
    heapError error;                                // Result of the table checks
  } storeRequest;

endpackage
